// File: logic/ppu_params.svh
// ------------------------------------------------
// VGA line and frame timing, dot counter geometry
// NMI event positions, blanking colour
// Reset palettes and CPU address windows
// ------------------------------------------------
`ifndef PPU_PARAMS_SVH
`define PPU_PARAMS_SVH

// Horizontal timing in 25 MHz clocks
`define PPU_H_VISIBLE 640
`define PPU_H_FRONT 16
`define PPU_H_SYNC 96
`define PPU_H_BACK 48
`define PPU_H_WHOLE 800

// Vertical timing in lines
`define PPU_V_VISIBLE 480
`define PPU_V_FRONT 10
`define PPU_V_SYNC 2
`define PPU_V_BACK 33
`define PPU_V_WHOLE 525

// Dot counter, 341 dots per line
`define PPU_DOT_LAST 340
`define PPU_NMI_LINE 256
`define PPU_NMI_CLEAR_DOT 296
`define PPU_NMI_CLEAR_LINE 15

// Master palette index shown in blanking
`define PPU_BLACK 6'h3F

// Entry 15 first, entry 0 in the low bits
`define PPU_PAL_BG_INIT {6'h10, 6'h28, 6'h38, 6'h00, 6'h30, 6'h00, 6'h26, 6'h00, \
                         6'h07, 6'h26, 6'h16, 6'h00, 6'h38, 6'h30, 6'h16, 6'h0F}
`define PPU_PAL_SP_INIT {6'h30, 6'h30, 6'h30, 6'h0F, 6'h27, 6'h28, 6'h39, 6'h0F, \
                         6'h16, 6'h2B, 6'h30, 6'h0F, 6'h12, 6'h27, 6'h16, 6'h0F}

// Registers at $2000-$3FFF, addr[15:13]
`define PPU_REG_WINDOW 3'b001
// Palette page $3Fxx, addr[15:8]
`define PPU_PAL_PAGE 8'h3F

`endif

// File: logic/ppu_video_pkg.sv
// ------------------------------------------------
// Video types: beam and dot position,
// 12-bit RGB pixel, master palette index
// ------------------------------------------------
package ppu_video_pkg;

    // VGA beam plus emulated dot position
    typedef struct packed {
        logic [9:0] vga_x;
        logic [9:0] vga_y;
        logic [8:0] dot_x;
        logic [8:0] dot_y;
    } scan_pos_t;

    // 4 bits per gun, red in the top nibble
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    // Index into the 64-colour master table
    typedef logic [5:0] color_idx_t;

endpackage

// File: logic/ppu_bus_pkg.sv
// ------------------------------------------------
// CPU bus types: request word, register select,
// phase of the three-dot access cycle
// ------------------------------------------------
package ppu_bus_pkg;

    // One CPU access as held for a whole cycle
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        we;
        logic        re;
    } cpu_req_t;

    // Low three address bits in the register window
    typedef enum logic [2:0] {
        REG_CTRL,
        REG_MASK,
        REG_STATUS,
        REG_OAM_ADDR,
        REG_OAM_DATA,
        REG_SCROLL,
        REG_ADDR,
        REG_DATA
    } reg_sel_e;

    // Sequencer phase, one step per dot
    typedef enum logic [1:0] {
        PHASE_IDLE,
        PHASE_REQUEST,
        PHASE_RESPOND
    } bus_phase_e;

endpackage

// File: logic/scan_timer.sv
// ------------------------------------------------
// Beam counter for 800x525 VGA, 341x262 dot
// counter, sync, visible window and NMI events
// ------------------------------------------------
`timescale 1ns/1ps
`include "ppu_params.svh"

module scan_timer (
    input  logic                     clock25,
    input  logic                     reset_n,
    output ppu_video_pkg::scan_pos_t pos_o,
    output logic                     dot_en_o,
    output logic                     vga_window_o,
    output logic                     hsync_o,
    output logic                     vsync_o,
    output logic                     nmi_set_o,
    output logic                     nmi_clear_o
);
    import ppu_video_pkg::*;

    scan_pos_t pos_q;
    logic      x_last;
    logic      y_last;
    logic      dot_wrap;

    assign x_last   = pos_q.vga_x == `PPU_H_WHOLE - 1;
    assign y_last   = pos_q.vga_y == `PPU_V_WHOLE - 1;
    assign dot_wrap = pos_q.dot_x == `PPU_DOT_LAST;

    // One dot per 2x2 VGA pixels, odd lines only
    // 682 clocks from the end of the back porch
    assign dot_en_o = pos_q.vga_x[0] && pos_q.vga_y[0]
                   && pos_q.vga_x >= `PPU_H_BACK
                   && pos_q.vga_x < `PPU_H_BACK + 2 * (`PPU_DOT_LAST + 1);

    // ------------------------------------------------
    // Counters
    // ------------------------------------------------
    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            pos_q.vga_x <= 10'd0;
            pos_q.vga_y <= 10'd1;
            pos_q.dot_x <= 9'd0;
            // Frame starts at dot line 16
            pos_q.dot_y <= 9'd16;
        end else begin
            pos_q.vga_x <= x_last ? 10'd0 : pos_q.vga_x + 10'd1;
            if (x_last) begin
                pos_q.vga_y <= y_last ? 10'd0 : pos_q.vga_y + 10'd1;
            end
            // Last VGA line rewinds the whole dot frame
            if (y_last) begin
                pos_q.dot_x <= 9'd0;
                pos_q.dot_y <= 9'd0;
            end else if (x_last) begin
                pos_q.dot_x <= 9'd0;
            end else if (dot_en_o) begin
                pos_q.dot_x <= dot_wrap ? 9'd0 : pos_q.dot_x + 9'd1;
                if (dot_wrap) begin
                    pos_q.dot_y <= pos_q.dot_y + 9'd1;
                end
            end
        end
    end

    assign pos_o = pos_q;

    // ------------------------------------------------
    // Decodes
    // ------------------------------------------------
    // Sync pulses after back porch, picture and front porch
    assign hsync_o = pos_q.vga_x < `PPU_H_BACK + `PPU_H_VISIBLE + `PPU_H_FRONT;
    assign vsync_o = pos_q.vga_y < `PPU_V_BACK + `PPU_V_VISIBLE + `PPU_V_FRONT;

    assign vga_window_o = pos_q.vga_x >= `PPU_H_BACK
                       && pos_q.vga_x < `PPU_H_BACK + `PPU_H_VISIBLE
                       && pos_q.vga_y >= `PPU_V_BACK
                       && pos_q.vga_y < `PPU_V_BACK + `PPU_V_VISIBLE;

    // Vertical blank begins and ends, one dot wide
    assign nmi_set_o   = dot_en_o && pos_q.dot_x == 0
                      && pos_q.dot_y == `PPU_NMI_LINE;
    assign nmi_clear_o = dot_en_o && pos_q.dot_x == `PPU_NMI_CLEAR_DOT
                      && pos_q.dot_y == `PPU_NMI_CLEAR_LINE;

endmodule

// File: logic/cpu_bus_fsm.sv
// ------------------------------------------------
// Three-dot CPU access sequencer
// CPU clock enable, request latch, strobes
// ------------------------------------------------
`timescale 1ns/1ps

module cpu_bus_fsm (
    input  logic                  clock25,
    input  logic                  reset_n,
    input  logic                  dot_en_i,
    input  ppu_bus_pkg::cpu_req_t cpu_req_i,
    output logic                  ce_cpu_o,
    output ppu_bus_pkg::cpu_req_t req_o,
    output logic                  req_stb_o,
    output logic                  rsp_stb_o
);
    import ppu_bus_pkg::*;

    bus_phase_e phase_q;

    // IDLE -> REQUEST -> RESPOND -> IDLE, one step per dot
    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            // First dot enters IDLE and starts a CPU cycle
            phase_q   <= PHASE_RESPOND;
            ce_cpu_o  <= 1'b0;
            req_stb_o <= 1'b0;
            rsp_stb_o <= 1'b0;
        end else begin
            ce_cpu_o  <= 1'b0;
            req_stb_o <= 1'b0;
            rsp_stb_o <= 1'b0;
            if (dot_en_i) begin
                case (phase_q)
                    PHASE_IDLE: begin
                        phase_q   <= PHASE_REQUEST;
                        req_stb_o <= 1'b1;
                    end
                    PHASE_REQUEST: begin
                        phase_q   <= PHASE_RESPOND;
                        rsp_stb_o <= 1'b1;
                    end
                    default: begin
                        // One 3-dot cycle per CPU clock
                        phase_q  <= PHASE_IDLE;
                        ce_cpu_o <= 1'b1;
                    end
                endcase
            end
        end
    end

    // Request held until the next REQUEST
    always_ff @(posedge clock25) begin
        if (dot_en_i && phase_q == PHASE_IDLE) begin
            req_o <= cpu_req_i;
        end
    end

endmodule

// File: logic/ppu_registers.sv
// ------------------------------------------------
// Control ($2000), status ($2002), video address
// ($2006), data port ($2007) and vblank NMI
// ------------------------------------------------
`timescale 1ns/1ps
`include "ppu_params.svh"

module ppu_registers (
    input  logic                  clock25,
    input  logic                  reset_n,
    input  ppu_bus_pkg::cpu_req_t req_i,
    input  logic                  req_stb_i,
    input  logic                  rsp_stb_i,
    input  logic                  nmi_set_i,
    input  logic                  nmi_clear_i,
    output logic [7:0]            reg_rdata_o,
    output logic                  nmi_o,
    output logic [14:0]           vid_addr_o,
    output logic [7:0]            vid_wdata_o,
    output logic                  vid_we_o,
    input  logic [7:0]            vid_rdata_i
);
    import ppu_bus_pkg::*;

    reg_sel_e    sel;
    logic        reg_hit;
    logic        wr_stb;
    logic        rd_stb;
    logic [7:0]  ctrl_q;
    logic        toggle_q;
    logic [14:0] vaddr_q;
    logic [14:0] vaddr_step;
    logic [7:0]  rbuf_q;

    // Palette page is served elsewhere
    assign reg_hit = req_i.addr[15:13] == `PPU_REG_WINDOW
                  && req_i.addr[15:8] != `PPU_PAL_PAGE;
    assign sel     = reg_sel_e'(req_i.addr[2:0]);
    assign wr_stb  = req_stb_i && reg_hit && req_i.we;
    assign rd_stb  = req_stb_i && reg_hit && req_i.re;

    // Bit 2 selects a step across one row of 32
    assign vaddr_step = ctrl_q[2] ? 15'd32 : 15'd1;

    // ------------------------------------------------
    // Control state
    // ------------------------------------------------
    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            ctrl_q   <= 8'h00;
            toggle_q <= 1'b0;
            vaddr_q  <= 15'd0;
            nmi_o    <= 1'b0;
            vid_we_o <= 1'b0;
        end else begin
            vid_we_o <= 1'b0;
            if (wr_stb) begin
                case (sel)
                    REG_CTRL: ctrl_q <= req_i.wdata;
                    REG_ADDR: begin
                        // High byte first, then low byte
                        if (!toggle_q) begin
                            vaddr_q[14:8] <= req_i.wdata[6:0];
                        end else begin
                            vaddr_q[7:0] <= req_i.wdata;
                        end
                        toggle_q <= ~toggle_q;
                    end
                    REG_DATA: begin
                        vaddr_q  <= vaddr_q + vaddr_step;
                        vid_we_o <= 1'b1;
                    end
                    default: ;
                endcase
            end else if (rd_stb) begin
                case (sel)
                    REG_STATUS: toggle_q <= 1'b0;
                    REG_DATA:   vaddr_q <= vaddr_q + vaddr_step;
                    default: ;
                endcase
            end
            // Set and clear lines never meet
            if (nmi_set_i) begin
                nmi_o <= ctrl_q[7];
            end else if (nmi_clear_i) begin
                nmi_o <= 1'b0;
            end
        end
    end

    // ------------------------------------------------
    // Data path
    // ------------------------------------------------
    always_ff @(posedge clock25) begin
        if (wr_stb && sel == REG_DATA) begin
            vid_addr_o  <= vaddr_q;
            vid_wdata_o <= req_i.wdata;
        end
        if (rd_stb) begin
            case (sel)
                REG_STATUS: reg_rdata_o <= {nmi_o, 7'd0};
                REG_DATA: begin
                    // Buffered read, fresh byte lands at RESPOND
                    reg_rdata_o <= rbuf_q;
                    vid_addr_o  <= vaddr_q;
                end
                default: reg_rdata_o <= 8'h00;
            endcase
        end
        if (rsp_stb_i && reg_hit && req_i.re && sel == REG_DATA) begin
            rbuf_q <= vid_rdata_i;
        end
    end

endmodule

// File: logic/palette_ram.sv
// ------------------------------------------------
// 32-entry palette at $3F00-$3F1F
// CPU read/write port and backdrop read port
// ------------------------------------------------
`timescale 1ns/1ps
`include "ppu_params.svh"

module palette_ram (
    input  logic                      clock25,
    input  logic                      reset_n,
    input  ppu_bus_pkg::cpu_req_t     req_i,
    input  logic                      req_stb_i,
    output ppu_video_pkg::color_idx_t pal_rdata_o,
    output ppu_video_pkg::color_idx_t backdrop_o
);
    import ppu_video_pkg::*;

    // Background entries 0-15, sprite entries 16-31
    localparam logic [31:0][5:0] pal_init = {`PPU_PAL_SP_INIT, `PPU_PAL_BG_INIT};

    color_idx_t pal_q [32];
    logic       pal_hit;

    // $3F00-$3F1F only, the rest of the page reads 0
    assign pal_hit = req_i.addr[15:8] == `PPU_PAL_PAGE && req_i.addr[7:5] == 3'b000;

    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            for (int i = 0; i < 32; i++) begin
                pal_q[i] <= pal_init[i];
            end
            pal_rdata_o <= '0;
        end else if (req_stb_i) begin
            if (pal_hit && req_i.we) begin
                pal_q[req_i.addr[4:0]] <= req_i.wdata[5:0];
            end
            if (req_i.re) begin
                pal_rdata_o <= pal_hit ? pal_q[req_i.addr[4:0]] : '0;
            end
        end
    end

    // Universal background colour
    assign backdrop_o = pal_q[0];

endmodule

// File: logic/color_encoder.sv
// ------------------------------------------------
// Pixel colour register and 64-entry NES
// master palette to 12-bit RGB table
// ------------------------------------------------
`timescale 1ns/1ps
`include "ppu_params.svh"

module color_encoder (
    input  logic                      clock25,
    input  logic                      reset_n,
    input  logic                      vga_window_i,
    input  ppu_video_pkg::color_idx_t backdrop_i,
    output ppu_video_pkg::rgb_t       rgb_o
);
    import ppu_video_pkg::*;

    // Rows of 16, $xD-$xF are black
    localparam logic [11:0] nes_table [64] = '{
        12'h777, 12'h218, 12'h00A, 12'h409, 12'h807, 12'hA01, 12'hA00, 12'h700,
        12'h420, 12'h040, 12'h050, 12'h031, 12'h135, 12'h000, 12'h000, 12'h000,
        12'hBBB, 12'h07E, 12'h23E, 12'h80F, 12'hB0B, 12'hE05, 12'hD20, 12'hC40,
        12'h870, 12'h090, 12'h0A0, 12'h093, 12'h088, 12'h000, 12'h000, 12'h000,
        12'hFFF, 12'h3BF, 12'h59F, 12'hA8F, 12'hF7F, 12'hF7B, 12'hF76, 12'hF93,
        12'hFB3, 12'h8D1, 12'h4D4, 12'h5F9, 12'h0ED, 12'h000, 12'h000, 12'h000,
        12'hFFF, 12'hAEF, 12'hCDF, 12'hDCF, 12'hFCF, 12'hFCD, 12'hFBB, 12'hFDA,
        12'hFEA, 12'hEFA, 12'hAFB, 12'hBFC, 12'h9FF, 12'h000, 12'h000, 12'h000
    };

    color_idx_t idx_q;

    // Backdrop in the picture, black in blanking
    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            idx_q <= `PPU_BLACK;
        end else begin
            idx_q <= vga_window_i ? backdrop_i : `PPU_BLACK;
        end
    end

    // One clock behind the beam
    assign rgb_o = nes_table[idx_q];

endmodule

// File: logic/ppu_top.sv
// ------------------------------------------------
// Picture processor top with timer, bus sequencer,
// registers, palette and colour encoder
// ------------------------------------------------
`timescale 1ns/1ps
`include "ppu_params.svh"

module ppu_top (
    input  logic                  clock25,
    input  logic                  reset_n,
    input  ppu_bus_pkg::cpu_req_t cpu_req_i,
    output logic [7:0]            cpu_rdata_o,
    output logic                  ce_cpu_o,
    output logic                  nmi_o,
    output logic [14:0]           vid_addr_o,
    output logic [7:0]            vid_wdata_o,
    output logic                  vid_we_o,
    input  logic [7:0]            vid_rdata_i,
    output ppu_video_pkg::rgb_t   rgb_o,
    output logic                  hsync_o,
    output logic                  vsync_o
);
    import ppu_bus_pkg::*;
    import ppu_video_pkg::*;

    // Timing
    logic       dot_en;
    logic       vga_window;
    logic       nmi_set;
    logic       nmi_clear;

    // CPU side
    cpu_req_t   req;
    logic       req_stb;
    logic       rsp_stb;
    logic [7:0] reg_rdata;
    color_idx_t pal_rdata;
    color_idx_t backdrop;

    scan_timer u_scan_timer (
        .clock25      (clock25),
        .reset_n      (reset_n),
        .pos_o        (),
        .dot_en_o     (dot_en),
        .vga_window_o (vga_window),
        .hsync_o      (hsync_o),
        .vsync_o      (vsync_o),
        .nmi_set_o    (nmi_set),
        .nmi_clear_o  (nmi_clear)
    );

    cpu_bus_fsm u_cpu_bus_fsm (
        .clock25   (clock25),
        .reset_n   (reset_n),
        .dot_en_i  (dot_en),
        .cpu_req_i (cpu_req_i),
        .ce_cpu_o  (ce_cpu_o),
        .req_o     (req),
        .req_stb_o (req_stb),
        .rsp_stb_o (rsp_stb)
    );

    ppu_registers u_ppu_registers (
        .clock25     (clock25),
        .reset_n     (reset_n),
        .req_i       (req),
        .req_stb_i   (req_stb),
        .rsp_stb_i   (rsp_stb),
        .nmi_set_i   (nmi_set),
        .nmi_clear_i (nmi_clear),
        .reg_rdata_o (reg_rdata),
        .nmi_o       (nmi_o),
        .vid_addr_o  (vid_addr_o),
        .vid_wdata_o (vid_wdata_o),
        .vid_we_o    (vid_we_o),
        .vid_rdata_i (vid_rdata_i)
    );

    palette_ram u_palette_ram (
        .clock25     (clock25),
        .reset_n     (reset_n),
        .req_i       (req),
        .req_stb_i   (req_stb),
        .pal_rdata_o (pal_rdata),
        .backdrop_o  (backdrop)
    );

    color_encoder u_color_encoder (
        .clock25      (clock25),
        .reset_n      (reset_n),
        .vga_window_i (vga_window),
        .backdrop_i   (backdrop),
        .rgb_o        (rgb_o)
    );

    // Palette page answers from the palette and all else from the registers
    assign cpu_rdata_o = (req.addr[15:8] == `PPU_PAL_PAGE) ? {2'b00, pal_rdata} : reg_rdata;

endmodule

// File: tests/ppu_asserts.sv
// ------------------------------------------------
// Concurrent checks on the PPU top level:
// CPU enable width, video write strobe width,
// black picture during horizontal sync
// ------------------------------------------------
`timescale 1ns/1ps

module ppu_asserts (
    input logic                clock25,
    input logic                reset_n,
    input logic                ce_cpu_i,
    input logic                vid_we_i,
    input logic                hsync_i,
    input ppu_video_pkg::rgb_t rgb_i
);

    // One clock per CPU cycle start
    ce_single: assert property (@(posedge clock25) disable iff (!reset_n)
        ce_cpu_i |=> !ce_cpu_i)
        else $error("ce_cpu_o stayed high on two clocks in a row");

    // Video memory write strobe
    we_single: assert property (@(posedge clock25) disable iff (!reset_n)
        vid_we_i |=> !vid_we_i)
        else $error("vid_we_o lasted more than one clock");

    // Sync lies in blanking, so the guns are off
    rgb_dark: assert property (@(posedge clock25) disable iff (!reset_n)
        !hsync_i |-> rgb_i == 12'h000)
        else $error("rgb_o not black while hsync_o is low");

endmodule

bind ppu_top ppu_asserts u_ppu_asserts (
    .clock25  (clock25),
    .reset_n  (reset_n),
    .ce_cpu_i (ce_cpu_o),
    .vid_we_i (vid_we_o),
    .hsync_i  (hsync_o),
    .rgb_i    (rgb_o)
);

// File: tests/ppu_tb.sv
// ------------------------------------------------
// PPU top testbench with clock and reset,
// CPU bus driver, video memory model, NES colour
// reference, sync, palette, VRAM and NMI checks
// ------------------------------------------------
`timescale 1ns/1ps
`include "ppu_params.svh"

module ppu_tb;
    import ppu_bus_pkg::*;
    import ppu_video_pkg::*;

    localparam int FRAME_CYCLES = `PPU_H_WHOLE * `PPU_V_WHOLE;
    // Four frames leave one spare beyond the tests
    localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES;

    logic       clock25 = 1'b0;
    logic       reset_n;
    cpu_req_t   cpu_req;
    logic [7:0] cpu_rdata;
    logic       ce_cpu;
    logic       nmi;
    logic [14:0] vid_addr;
    logic [7:0] vid_wdata;
    logic       vid_we;
    logic [7:0] vid_rdata;
    rgb_t       rgb;
    logic       hsync;
    logic       vsync;

    integer      seed = 32'h4ec1_95c4;
    int          value_errors = 0;
    int          other_errors = 0;
    int unsigned cycle_count = 0;
    logic [7:0]  vram [32768];
    logic [7:0]  vram_exp [32768];
    int unsigned nmi_rise_cycles [$];
    // Colour checker control
    logic        rgb_check_on = 1'b0;
    logic        rgb_seen = 1'b0;
    color_idx_t  backdrop_exp = '0;

    ppu_top DUT (
        .clock25     (clock25),
        .reset_n     (reset_n),
        .cpu_req_i   (cpu_req),
        .cpu_rdata_o (cpu_rdata),
        .ce_cpu_o    (ce_cpu),
        .nmi_o       (nmi),
        .vid_addr_o  (vid_addr),
        .vid_wdata_o (vid_wdata),
        .vid_we_o    (vid_we),
        .vid_rdata_i (vid_rdata),
        .rgb_o       (rgb),
        .hsync_o     (hsync),
        .vsync_o     (vsync)
    );

    always #10 clock25 = ~clock25;

    // ------------------------------------------------
    // Reporting and reference models
    // ------------------------------------------------
    task automatic show_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] got_v);
        $display("[ERROR] %0t ns %s: expected %0h, got %0h", $time, name, exp_v, got_v);
        value_errors++;
    endtask

    task automatic flag_failure(input string msg);
        $display("Check failed at %0t ns: %s", $time, msg);
        other_errors++;
    endtask

    task automatic finish_run();
        $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    // NES master palette in rows of 16 with entry 0 leftmost
    function automatic logic [11:0] nes_rgb(input logic [5:0] idx);
        logic [191:0] row;
        case (idx[5:4])
            2'd0: row = 192'h777218_00A409_807A01_A00700_420040_050031_135000_000000;
            2'd1: row = 192'hBBB07E_23E80F_B0BE05_D20C40_870090_0A0093_088000_000000;
            2'd2: row = 192'hFFF3BF_59FA8F_F7FF7B_F76F93_FB38D1_4D45F9_0ED000_000000;
            default: row = 192'hFFFAEF_CDFDCF_FCFFCD_FBBFDA_FEAEFA_AFBBFC_9FF000_000000;
        endcase
        return row[(15 - idx[3:0]) * 12 +: 12];
    endfunction

    // Power-up contents of video memory
    function automatic logic [7:0] fill_byte(input logic [14:0] a);
        return a[7:0] ^ {1'b0, a[14:8]} ^ 8'hA5;
    endfunction

    function automatic int count_rises(input int unsigned lo, input int unsigned hi);
        int n;
        n = 0;
        foreach (nmi_rise_cycles[k]) begin
            if (nmi_rise_cycles[k] >= lo && nmi_rise_cycles[k] < hi) begin
                n++;
            end
        end
        return n;
    endfunction

    // ------------------------------------------------
    // Video memory model
    // ------------------------------------------------
    initial begin
        for (int a = 0; a < 32768; a++) begin
            vram[a] = fill_byte(15'(a));
            vram_exp[a] = fill_byte(15'(a));
        end
    end

    always @(posedge clock25) begin
        if (vid_we) begin
            vram[vid_addr] <= vid_wdata;
        end
    end

    assign vid_rdata = vram[vid_addr];

    // Cycle count and run limit
    always @(posedge clock25) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            flag_failure("timeout, the tests did not finish within four frames");
            finish_run();
        end
    end

    // ------------------------------------------------
    // Monitors sampled on the falling edge
    // ------------------------------------------------
    int   h_low = 0;
    int   h_since = 0;
    int   h_falls = 0;
    int   v_low = 0;
    int   v_since = 0;
    int   v_falls = 0;
    logic hsync_d = 1'b1;
    logic vsync_d = 1'b1;
    logic nmi_d = 1'b0;
    logic ce_d = 1'b0;
    logic we_d = 1'b0;

    // Sync pulse widths and periods
    always @(negedge clock25) begin
        if (reset_n) begin
            h_since++;
            v_since++;
            if (!hsync) h_low = hsync_d ? 1 : h_low + 1;
            if (!vsync) v_low = vsync_d ? 1 : v_low + 1;
            if (hsync && !hsync_d && h_low != `PPU_H_SYNC) begin
                show_mismatch("hsync_o low clocks", `PPU_H_SYNC, h_low);
            end
            if (vsync && !vsync_d && v_low != `PPU_V_SYNC * `PPU_H_WHOLE) begin
                show_mismatch("vsync_o low clocks", `PPU_V_SYNC * `PPU_H_WHOLE, v_low);
            end
            if (!hsync && hsync_d) begin
                if (h_falls > 0 && h_since != `PPU_H_WHOLE) begin
                    show_mismatch("hsync_o period", `PPU_H_WHOLE, h_since);
                end
                h_falls++;
                h_since = 0;
            end
            if (!vsync && vsync_d) begin
                if (v_falls > 0 && v_since != FRAME_CYCLES) begin
                    show_mismatch("vsync_o period", FRAME_CYCLES, v_since);
                end
                v_falls++;
                v_since = 0;
            end
            hsync_d = hsync;
            vsync_d = vsync;
        end
    end

    // Colour, strobe widths and NMI edges
    always @(negedge clock25) begin
        if (reset_n) begin
            if (!hsync && rgb != 12'h000) begin
                show_mismatch("rgb_o during hsync", 12'h000, rgb);
            end
            if (rgb_check_on && rgb != 12'h000) begin
                rgb_seen = 1'b1;
                if (rgb != nes_rgb(backdrop_exp)) begin
                    show_mismatch("rgb_o", nes_rgb(backdrop_exp), rgb);
                end
            end
            if (ce_d && ce_cpu) flag_failure("ce_cpu_o high on two clocks in a row");
            if (we_d && vid_we) flag_failure("vid_we_o high on two clocks in a row");
            if (nmi && !nmi_d) nmi_rise_cycles.push_back(cycle_count);
            ce_d = ce_cpu;
            we_d = vid_we;
            nmi_d = nmi;
        end
    end

    // ------------------------------------------------
    // CPU bus driver
    // ------------------------------------------------
    task automatic wait_ce();
        @(negedge clock25);
        while (!ce_cpu) @(negedge clock25);
    endtask

    // Drive just after the enable and read data at the next one
    task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] wdata,
                             input logic we, input logic re, output logic [7:0] rdata);
        @(posedge clock25);
        cpu_req <= '{addr: addr, wdata: wdata, we: we, re: re};
        wait_ce();
        rdata = cpu_rdata;
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [7:0] wdata);
        logic [7:0] unused;
        bus_cycle(addr, wdata, 1'b1, 1'b0, unused);
    endtask

    task automatic read_reg(input logic [15:0] addr, output logic [7:0] rdata);
        bus_cycle(addr, 8'h00, 1'b0, 1'b1, rdata);
    endtask

    task automatic idle_bus();
        logic [7:0] unused;
        bus_cycle(16'h0000, 8'h00, 1'b0, 1'b0, unused);
    endtask

    // Status read resets the write toggle before high and low byte
    task automatic set_vaddr(input logic [14:0] a);
        logic [7:0] unused;
        read_reg(16'h2002, unused);
        write_reg(16'h2006, {1'b0, a[14:8]});
        write_reg(16'h2006, a[7:0]);
    endtask

    // ------------------------------------------------
    // Tests
    // ------------------------------------------------
    task automatic palette_readback();
        logic [5:0] pal_exp [32];
        logic [7:0] d;
        for (int i = 0; i < 32; i++) begin
            d = $random(seed);
            pal_exp[i] = d[5:0];
            write_reg(16'h3F00 + i, d);
        end
        for (int i = 0; i < 32; i++) begin
            read_reg(16'h3F00 + i, d);
            if (d != {2'b00, pal_exp[i]}) show_mismatch($sformatf("palette[%0d]", i),
                                                         {2'b00, pal_exp[i]}, d);
        end
        // Past the palette entries
        read_reg(16'h3F20, d);
        if (d != 8'h00) show_mismatch("cpu_rdata_o at $3F20", 8'h00, d);
    endtask

    task automatic backdrop_colour();
        logic [7:0] d;
        do begin
            d = $random(seed);
        end while (nes_rgb(d[5:0]) == 12'h000);
        write_reg(16'h3F00, d);
        idle_bus();
        backdrop_exp = d[5:0];
        rgb_seen = 1'b0;
        rgb_check_on = 1'b1;
        repeat (FRAME_CYCLES) @(negedge clock25);
        rgb_check_on = 1'b0;
        // Back in step with the CPU cycle before the next access
        wait_ce();
        if (!rgb_seen) flag_failure("no backdrop colour appeared on rgb_o for a frame");
    endtask

    task automatic vram_access();
        logic [14:0] base;
        logic [14:0] a;
        logic [7:0]  d;
        // Step of 1
        write_reg(16'h2000, 8'h00);
        base = $random(seed);
        set_vaddr(base);
        for (int i = 0; i < 8; i++) begin
            d = $random(seed);
            write_reg(16'h2007, d);
            vram_exp[base + 15'(i)] = d;
        end
        for (int i = 0; i < 8; i++) begin
            a = base + 15'(i);
            if (vram[a] != vram_exp[a]) show_mismatch($sformatf("vram[%h]", a),
                                                       vram_exp[a], vram[a]);
        end
        // Buffered reads lag by one access
        set_vaddr(base);
        read_reg(16'h2007, d);
        for (int i = 0; i < 8; i++) begin
            a = base + 15'(i);
            read_reg(16'h2007, d);
            if (d != vram_exp[a]) show_mismatch("cpu_rdata_o from $2007", vram_exp[a], d);
        end
        // Step of 32 moves one row down per access
        write_reg(16'h2000, 8'h04);
        base = $random(seed);
        set_vaddr(base);
        for (int i = 0; i < 8; i++) begin
            d = $random(seed);
            write_reg(16'h2007, d);
            vram_exp[base + 15'(32 * i)] = d;
        end
        idle_bus();
        for (int i = 0; i < 8; i++) begin
            a = base + 15'(32 * i);
            if (vram[a] != vram_exp[a]) show_mismatch($sformatf("vram[%h]", a),
                                                       vram_exp[a], vram[a]);
        end
    endtask

    task automatic nmi_frames();
        int unsigned start;
        logic        nmi_before;
        logic        status_one = 1'b0;
        logic [7:0]  d;
        // NMI enabled with status polled for one frame
        write_reg(16'h2000, 8'h80);
        start = cycle_count;
        nmi_before = nmi;
        while (cycle_count - start < FRAME_CYCLES) begin
            read_reg(16'h2002, d);
            // Skip accesses that straddle an NMI edge
            if (nmi == nmi_before) begin
                if (d[7] != nmi) show_mismatch("status bit 7", nmi, d[7]);
                if (d[7]) status_one = 1'b1;
            end
            nmi_before = nmi;
        end
        if (count_rises(start, start + FRAME_CYCLES) != 1) begin
            show_mismatch("nmi_o rises per frame", 1, count_rises(start, start + FRAME_CYCLES));
        end
        if (!status_one) flag_failure("status bit 7 never read 1 while nmi_o was high");
        // A pending NMI still ends at its clear line once disabled
        write_reg(16'h2000, 8'h00);
        idle_bus();
        while (nmi) @(negedge clock25);
        start = cycle_count;
        repeat (FRAME_CYCLES) @(negedge clock25);
        if (count_rises(start, start + FRAME_CYCLES) != 0) begin
            show_mismatch("nmi_o rises with bit 7 clear", 0,
                          count_rises(start, start + FRAME_CYCLES));
        end
    endtask

    initial begin
        cpu_req = '0;
        reset_n = 1'b0;
        repeat (8) @(posedge clock25);
        reset_n <= 1'b1;
        wait_ce();
        palette_readback();
        backdrop_colour();
        vram_access();
        nmi_frames();
        if (h_falls < 2) flag_failure("no complete hsync_o period was observed");
        if (v_falls < 2) flag_failure("no complete vsync_o period was observed");
        finish_run();
    end

endmodule

// File: tb.f
+incdir+logic
logic/ppu_video_pkg.sv
logic/ppu_bus_pkg.sv
logic/scan_timer.sv
logic/cpu_bus_fsm.sv
logic/ppu_registers.sv
logic/palette_ram.sv
logic/color_encoder.sv
logic/ppu_top.sv
tests/ppu_asserts.sv
tests/ppu_tb.sv
